//--- build.f
+incdir+.
qspi_pkg.sv
qspi_sync.sv
flash_mem.sv
flash_cmd.sv
qspi_flash_emu.sv
tb_qspi_flash_emu.sv

//--- flash_cmd.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_consts.svh"

module flash_cmd (
	input wire clk,
	input wire rst_n,
	input wire start_strobe,
	input wire byte_strobe,
	input wire qspi_pkg::byte_t rx_byte,
	output logic wr_en,
	output qspi_pkg::mem_addr_t wr_addr,
	output qspi_pkg::byte_t wr_data,
	output qspi_pkg::mem_addr_t rd_addr
);

	qspi_pkg::cmd_state_t state;

	// command was a quad read rather than a program
	logic is_read;
	logic [1:0] addr_cnt;
	qspi_pkg::flash_addr_t addr_shift;
	qspi_pkg::flash_addr_t next_addr;
	logic data_strobe;
	logic addr_done;

	// address arrives most significant byte first
	assign next_addr = {addr_shift[15:0], rx_byte};

	// a byte after the command byte
	assign data_strobe = byte_strobe && !start_strobe;

	assign addr_done = data_strobe && (state == qspi_pkg::ADDR) &&
		(addr_cnt == 2'(`QSPI_ADDR_BYTES - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= qspi_pkg::IDLE;
			is_read <= 1'b0;
			addr_cnt <= 2'd0;
			wr_en <= 1'b0;
			rd_addr <= '0;
		end
		else
		begin
			wr_en <= 1'b0;

			if (start_strobe)
			begin
				addr_cnt <= 2'd0;
				if (rx_byte == `QSPI_CMD_PROG || rx_byte == `QSPI_CMD_QREAD)
				begin
					state <= qspi_pkg::ADDR;
					is_read <= (rx_byte == `QSPI_CMD_QREAD);
				end
				else
					state <= qspi_pkg::IGNORE;
			end
			else if (data_strobe)
			begin
				case (state)
					qspi_pkg::ADDR:
					begin
						addr_cnt <= addr_cnt + 2'd1;
						if (addr_done)
						begin
							if (is_read)
							begin
								state <= qspi_pkg::READ_DATA;
								// only the low bits select a byte
								rd_addr <= next_addr[`QSPI_MEM_AW-1:0];
							end
							else
								state <= qspi_pkg::PROG_DATA;
						end
					end
					qspi_pkg::PROG_DATA:
						wr_en <= 1'b1;
					qspi_pkg::READ_DATA:
						rd_addr <= rd_addr + 1'b1;
					default:
						;
				endcase
			end
		end
	end

	// address and write data path
	always_ff @(posedge clk)
	begin
		if (data_strobe && state == qspi_pkg::ADDR)
			addr_shift <= next_addr;

		if (data_strobe && state == qspi_pkg::PROG_DATA)
			wr_data <= rx_byte;

		// step to the next byte once the current write is done
		if (addr_done)
			wr_addr <= next_addr[`QSPI_MEM_AW-1:0];
		else if (wr_en)
			wr_addr <= wr_addr + 1'b1;
	end

	assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> state == qspi_pkg::PROG_DATA)
		else $error("memory write outside of a program command");

endmodule

`default_nettype wire

//--- flash_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_consts.svh"

module flash_mem (
	input wire clk,
	input wire wr_en,
	input wire qspi_pkg::mem_addr_t wr_addr,
	input wire qspi_pkg::byte_t wr_data,
	input wire qspi_pkg::mem_addr_t rd_addr,
	output qspi_pkg::byte_t rd_data
);

	localparam int DEPTH = 1 << `QSPI_MEM_AW;

	qspi_pkg::byte_t mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// same-cycle read of a written address sees the old byte
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- qspi_consts.svh
`ifndef QSPI_CONSTS_SVH
`define QSPI_CONSTS_SVH

// memory address width, depth is 2**QSPI_MEM_AW bytes
`define QSPI_MEM_AW 10

// flash command codes, always received on a single data line
`define QSPI_CMD_PROG 8'h02
`define QSPI_CMD_QREAD 8'hEB

// address bytes that follow a command
`define QSPI_ADDR_BYTES 3

// bits per SPI clock on the data lines
`define QSPI_MODE_SINGLE 3'd1
`define QSPI_MODE_QUAD 3'd4

`endif

//--- qspi_flash_emu.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_flash_emu (
	input wire clk,
	input wire rst_n,
	input wire spi_cs_in,
	input wire spi_clk_in,
	input wire qspi_pkg::nibble_t spi_data_in,
	output qspi_pkg::nibble_t spi_data_out
);

	wire start_strobe;
	wire byte_strobe;
	qspi_pkg::byte_t rx_byte;

	wire wr_en;
	qspi_pkg::mem_addr_t wr_addr;
	qspi_pkg::byte_t wr_data;
	qspi_pkg::mem_addr_t rd_addr;

	// memory read data is the next byte to send
	qspi_pkg::byte_t rd_data;

	qspi_sync i_sync (
		.clk(clk),
		.rst_n(rst_n),
		.spi_cs_in(spi_cs_in),
		.spi_clk_in(spi_clk_in),
		.spi_data_in(spi_data_in),
		.tx_byte(rd_data),
		.spi_data_out(spi_data_out),
		.start_strobe(start_strobe),
		.byte_strobe(byte_strobe),
		.rx_byte(rx_byte)
	);

	flash_cmd i_cmd (
		.clk(clk),
		.rst_n(rst_n),
		.start_strobe(start_strobe),
		.byte_strobe(byte_strobe),
		.rx_byte(rx_byte),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr)
	);

	flash_mem i_mem (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

//--- qspi_pkg.sv
`default_nettype none

package qspi_pkg;

	`include "qspi_consts.svh"

	// one command, address or data byte
	typedef logic [7:0] byte_t;

	// value of the four QSPI data lines
	typedef logic [3:0] nibble_t;

	// byte address inside the emulated memory
	typedef logic [`QSPI_MEM_AW-1:0] mem_addr_t;

	// full 24-bit address as sent by the host
	typedef logic [23:0] flash_addr_t;

	// command decoder states
	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		PROG_DATA,
		READ_DATA,
		IGNORE
	} cmd_state_t;

endpackage

`default_nettype wire

//--- qspi_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_consts.svh"

module qspi_sync (
	input wire clk,
	input wire rst_n,
	input wire spi_cs_in,
	input wire spi_clk_in,
	input wire qspi_pkg::nibble_t spi_data_in,
	input wire qspi_pkg::byte_t tx_byte,
	output qspi_pkg::nibble_t spi_data_out,
	output logic start_strobe,
	output logic byte_strobe,
	output qspi_pkg::byte_t rx_byte
);

	// {cs, clk, data[3:0]} through three flops into the clk domain
	logic [5:0] pins_meta;
	logic [5:0] pins_mid;
	logic [5:0] pins_sync;

	logic spi_cs;
	logic spi_clk;
	qspi_pkg::nibble_t spi_data;
	logic spi_clk_prev;
	logic clk_rising;
	logic clk_falling;

	// bits per SPI clock on the data lines
	logic [2:0] mode;
	// bit position inside the current byte
	logic [2:0] bits;
	logic [2:0] next_bits;
	// first byte of this select already seen
	logic got_cmd;

	qspi_pkg::byte_t shift_rx;
	qspi_pkg::byte_t next_rx;
	qspi_pkg::byte_t shift_tx;

	assign spi_cs = pins_sync[5];
	assign spi_clk = pins_sync[4];
	assign spi_data = pins_sync[3:0];

	assign clk_rising = spi_clk && !spi_clk_prev;
	assign clk_falling = !spi_clk && spi_clk_prev;

	always_comb
	begin
		if (mode == `QSPI_MODE_QUAD)
			next_rx = {shift_rx[3:0], spi_data};
		else
			next_rx = {shift_rx[6:0], spi_data[0]};
	end

	// wraps to zero when a byte is complete
	assign next_bits = bits + mode;

	assign byte_strobe = !spi_cs && clk_rising && (next_bits == 3'd0);
	assign start_strobe = byte_strobe && !got_cmd;
	assign rx_byte = next_rx;

	// host always samples the top nibble
	assign spi_data_out = shift_tx[7:4];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// deselected with the SPI clock low
			pins_meta <= 6'b10_0000;
			pins_mid <= 6'b10_0000;
			pins_sync <= 6'b10_0000;
			spi_clk_prev <= 1'b0;
			mode <= `QSPI_MODE_SINGLE;
			bits <= 3'd0;
			got_cmd <= 1'b0;
		end
		else
		begin
			pins_meta <= {spi_cs_in, spi_clk_in, spi_data_in};
			pins_mid <= pins_meta;
			pins_sync <= pins_mid;
			spi_clk_prev <= spi_clk;

			if (spi_cs)
			begin
				mode <= `QSPI_MODE_SINGLE;
				bits <= 3'd0;
				got_cmd <= 1'b0;
			end
			else if (clk_rising)
			begin
				bits <= next_bits;
				if (byte_strobe)
				begin
					got_cmd <= 1'b1;
					// quad read command switches the rest of the select to 4 lines
					if (!got_cmd && next_rx == `QSPI_CMD_QREAD)
						mode <= `QSPI_MODE_QUAD;
				end
			end
		end
	end

	// receive and transmit shifters
	always_ff @(posedge clk)
	begin
		if (!spi_cs && clk_rising)
			shift_rx <= next_rx;

		if (!spi_cs && clk_falling)
		begin
			if (bits == 3'd0)
				shift_tx <= tx_byte;
			else if (mode == `QSPI_MODE_QUAD)
				shift_tx <= {shift_tx[3:0], 4'b0000};
			else
				shift_tx <= {shift_tx[6:0], 1'b0};
		end
	end

	// the command byte always arrives on a single data line
	assert property (@(posedge clk) disable iff (!rst_n)
		start_strobe |-> (mode == `QSPI_MODE_SINGLE))
		else $error("command byte received outside single-bit mode");

	// quad mode starts on a byte boundary and stays nibble aligned
	assert property (@(posedge clk) disable iff (!rst_n)
		(mode == `QSPI_MODE_QUAD) |-> (bits[1:0] == 2'b00))
		else $error("quad mode bit position %0d off a nibble boundary", bits);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_qspi_flash_emu -f build.f

./obj_dir/Vtb_qspi_flash_emu > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "run ended without a result line"
	exit 1
fi
exit 0

//--- tb_qspi_flash_emu.sv
`timescale 1ns/1ps
`default_nettype none

`include "qspi_consts.svh"

module tb_qspi_flash_emu;

	localparam int DEPTH = 1 << `QSPI_MEM_AW;
	localparam int MAX_LEN = 16;
	localparam int MAX_HALF = 12;
	localparam int NUM_RANDOM = 40;
	// twelve directed transactions come before the random ones
	localparam int NUM_TRANS = NUM_RANDOM + 12;
	// SPI clocks of the longest transaction plus the select and deselect gaps
	localparam int MAX_SPI_CLOCKS = (1 + `QSPI_ADDR_BYTES + MAX_LEN) * 8 + 2;
	localparam int TIMEOUT_CYCLES = NUM_TRANS * MAX_SPI_CLOCKS * 2 * MAX_HALF * 2;

	logic clk;
	logic rst_n;
	logic spi_cs_in;
	logic spi_clk_in;
	qspi_pkg::nibble_t spi_data_in;
	qspi_pkg::nibble_t spi_data_out;

	integer seed;
	int half_period;
	int cycles = 0;

	// expected memory contents and which bytes hold programmed data
	qspi_pkg::byte_t model_mem [DEPTH];
	bit programmed [DEPTH];

	qspi_flash_emu i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.spi_cs_in(spi_cs_in),
		.spi_clk_in(spi_clk_in),
		.spi_data_in(spi_data_in),
		.spi_data_out(spi_data_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_byte(input qspi_pkg::byte_t expected, input qspi_pkg::byte_t actual,
		input qspi_pkg::mem_addr_t addr);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t: read of address %0h returned %02h, expected %02h",
				$time, addr, actual, expected);
			$display("Simulation failed");
			$fatal(1, "read data mismatch");
		end
	endtask

	// new random SPI speed for every select
	task automatic spi_select();
		half_period = 6 + ($unsigned($random(seed)) % 7);
		spi_cs_in = 1'b0;
		repeat (half_period) @(negedge clk);
	endtask

	task automatic spi_deselect();
		repeat (half_period) @(negedge clk);
		spi_cs_in = 1'b1;
		spi_data_in = '0;
		repeat (half_period) @(negedge clk);
	endtask

	// one SPI clock that sets data while low and samples the DUT at the rising edge
	task automatic spi_clock(input qspi_pkg::nibble_t out_val, output qspi_pkg::nibble_t in_val);
		spi_data_in = out_val;
		repeat (half_period) @(negedge clk);
		spi_clk_in = 1'b1;
		in_val = spi_data_out;
		repeat (half_period) @(negedge clk);
		spi_clk_in = 1'b0;
	endtask

	// top nbits of a byte on data line 0 with the msb first
	task automatic send_single(input qspi_pkg::byte_t value, input int nbits);
		qspi_pkg::nibble_t unused;
		for (int i = 7; i > 7 - nbits; i--)
			spi_clock({3'b000, value[i]}, unused);
	endtask

	task automatic send_quad(input qspi_pkg::byte_t value);
		qspi_pkg::nibble_t unused;
		spi_clock(value[7:4], unused);
		spi_clock(value[3:0], unused);
	endtask

	task automatic recv_quad(output qspi_pkg::byte_t value);
		qspi_pkg::nibble_t high_nib;
		qspi_pkg::nibble_t low_nib;
		spi_clock(4'h0, high_nib);
		spi_clock(4'h0, low_nib);
		value = {high_nib, low_nib};
	endtask

	// tail_bits > 0 leaves a byte unfinished before the deselect
	task automatic program_range(input qspi_pkg::flash_addr_t addr, input int len,
		input int tail_bits);
		qspi_pkg::byte_t data;
		qspi_pkg::mem_addr_t idx;
		spi_select();
		send_single(`QSPI_CMD_PROG, 8);
		send_single(addr[23:16], 8);
		send_single(addr[15:8], 8);
		send_single(addr[7:0], 8);
		for (int k = 0; k < len; k++)
		begin
			data = qspi_pkg::byte_t'($random(seed));
			idx = qspi_pkg::mem_addr_t'(addr + k);
			send_single(data, 8);
			model_mem[idx] = data;
			programmed[idx] = 1'b1;
		end
		if (tail_bits > 0)
			send_single(qspi_pkg::byte_t'($random(seed)), tail_bits);
		spi_deselect();
	endtask

	task automatic read_range(input qspi_pkg::flash_addr_t addr, input int len);
		qspi_pkg::byte_t data;
		qspi_pkg::mem_addr_t idx;
		spi_select();
		send_single(`QSPI_CMD_QREAD, 8);
		send_quad(addr[23:16]);
		send_quad(addr[15:8]);
		send_quad(addr[7:0]);
		for (int k = 0; k < len; k++)
		begin
			recv_quad(data);
			idx = qspi_pkg::mem_addr_t'(addr + k);
			if (programmed[idx])
				check_byte(model_mem[idx], data, idx);
		end
		spi_deselect();
	endtask

	// quad read dropped in the middle of its address
	task automatic read_abort(input qspi_pkg::flash_addr_t addr);
		qspi_pkg::nibble_t unused;
		spi_select();
		send_single(`QSPI_CMD_QREAD, 8);
		send_quad(addr[23:16]);
		spi_clock(addr[15:12], unused);
		spi_deselect();
	endtask

	// unknown command shaped like a program of inverted data over a programmed range
	task automatic send_unknown(input qspi_pkg::byte_t cmd, input qspi_pkg::flash_addr_t addr,
		input int len);
		qspi_pkg::mem_addr_t idx;
		spi_select();
		send_single(cmd, 8);
		send_single(addr[23:16], 8);
		send_single(addr[15:8], 8);
		send_single(addr[7:0], 8);
		for (int k = 0; k < len; k++)
		begin
			idx = qspi_pkg::mem_addr_t'(addr + k);
			send_single(~model_mem[idx], 8);
		end
		spi_deselect();
	endtask

	initial
	begin
		qspi_pkg::flash_addr_t base;
		qspi_pkg::flash_addr_t addr;
		qspi_pkg::flash_addr_t last_prog;
		int len;
		rst_n = 1'b0;
		spi_cs_in = 1'b1;
		spi_clk_in = 1'b0;
		spi_data_in = '0;
		seed = 32'h3cac;
		half_period = MAX_HALF;
		for (int i = 0; i < DEPTH; i++)
			programmed[i] = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		base = qspi_pkg::flash_addr_t'($random(seed));
		program_range(base, 8, 0);
		read_range(base, 8);

		// both ranges cross the top of memory
		program_range(24'hA503FC, 10, 0);
		read_range(24'h0003FE, 6);

		send_unknown(8'h9F, base, 8);
		read_range(base, 8);

		// three full bytes land while the partial one and the rest keep old data
		addr = 24'h000100;
		program_range(addr, 8, 0);
		program_range(addr, 3, 5);
		read_range(addr, 8);

		// next select has to start again with single-bit commands
		read_abort(addr);
		program_range(addr + 24'd4, 4, 0);
		read_range(addr, 8);

		last_prog = base;
		for (int t = 0; t < NUM_RANDOM; t++)
		begin
			addr = qspi_pkg::flash_addr_t'($random(seed));
			len = 1 + ($unsigned($random(seed)) % MAX_LEN);
			if ($random(seed) & 1)
			begin
				program_range(addr, len, 0);
				last_prog = addr;
			end
			else
				read_range(last_prog, len);
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
